//--- tb.f
+incdir+.
tpu_types_pkg.sv
tpu_ctrl_pkg.sv
domain_if.sv
pub_domain_arbiter.sv
pub_domain_table.sv
pub_domain_top.sv
tb_pub_domain.sv

//--- run.sh
#!/bin/bash
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_pub_domain \
	-o sim_pub_domain > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_pub_domain > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "simulation did not finish"; exit 1; }
exit 0

//--- tb_pub_domain.sv
//////////////////////////////////////////////////////////////////////
// testbench for the publish-domain manager
// runs a store/load stimulus table against the top level and checks
// each ready response; the store arbiter's grant order is checked first
//////////////////////////////////////////////////////////////////////

`include "pub_domain_defs.svh"

module tb_pub_domain;
	timeunit 1ns;
	timeprecision 1ps;

	import tpu_types_pkg::*;
	import tpu_ctrl_pkg::*;

	localparam logic op_store = 1'b0;
	localparam logic op_load = 1'b1;
	localparam logic ends_done = 1'b1;
	localparam logic ends_blocked = 1'b0;

	// one row: side, unit, index into the base pool, and the expected outcome
	typedef struct packed {
		logic       is_load;
		req_no_t    who;
		logic [2:0] pick;
		logic       completes;
	} row_t;

	logic                clock;
	logic                reset;
	logic [`NUM_REQ-1:0] st_req;
	address_t            st_base_0;
	address_t            st_base_1;
	logic [`NUM_REQ-1:0] st_end;
	logic [`NUM_REQ-1:0] st_ready;
	logic [`NUM_REQ-1:0] ld_req;
	address_t            ld_base_0;
	address_t            ld_base_1;
	logic [`NUM_REQ-1:0] ld_end;
	logic [`NUM_REQ-1:0] ld_ready;

	row_t       rows [$];
	address_t   pool [8];
	integer     seed;
	arb_state_t st_arb_state;

	assign st_arb_state = i_pub_domain_top.i_st_arbiter.state;

	pub_domain_top i_pub_domain_top (
		.clock     (clock),
		.reset     (reset),
		.st_req    (st_req),
		.st_base_0 (st_base_0),
		.st_base_1 (st_base_1),
		.st_end    (st_end),
		.st_ready  (st_ready),
		.ld_req    (ld_req),
		.ld_base_0 (ld_base_0),
		.ld_base_1 (ld_base_1),
		.ld_end    (ld_end),
		.ld_ready  (ld_ready)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic stop_failed();
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped after a failure");
	endtask

	task automatic report_mismatch(input string msg);
		$display("FAILED at %0d ns: %s", $time, msg);
		stop_failed();
	endtask

	task automatic report_timeout(input string msg);
		$display("timeout: %s", msg);
		stop_failed();
	endtask

	function automatic logic ready_bit(input logic is_load, input req_no_t who);
		return is_load ? ld_ready[who] : st_ready[who];
	endfunction

	task automatic check_ready(input logic is_load, input req_no_t who, input logic expected);
		logic got;
		got = ready_bit(is_load, who);
		if (got !== expected) begin
			report_mismatch($sformatf("ready of %s unit %0d is %b, expected %b",
				is_load ? "load" : "store", who, got, expected));
		end
	endtask

	task automatic check_grant_order(input req_no_t expected);
		req_no_t got;
		if (st_ready == 2'b00 || st_ready == 2'b11) begin
			report_mismatch($sformatf("store ready is %b, expected one grant", st_ready));
		end
		got = st_ready[1] ? req_no_t'(1) : req_no_t'(0);
		$display("store grant to unit %0d, arbiter %s", got, st_arb_state.name());
		if (got !== expected) begin
			report_mismatch($sformatf("store grant went to unit %0d, expected %0d", got, expected));
		end
	endtask

	task automatic drive_req(input logic is_load, input req_no_t who, input logic on,
			input address_t base);
		if (is_load) begin
			ld_req[who] <= on;
			if (who == req_no_t'(0)) begin
				ld_base_0 <= base;
			end else begin
				ld_base_1 <= base;
			end
		end else begin
			st_req[who] <= on;
			if (who == req_no_t'(0)) begin
				st_base_0 <= base;
			end else begin
				st_base_1 <= base;
			end
		end
	endtask

	task automatic drive_end(input logic is_load, input req_no_t who, input logic val);
		if (is_load) begin
			ld_end[who] <= val;
		end else begin
			st_end[who] <= val;
		end
	endtask

	// polls at the falling edge, where the combinational ready has settled
	task automatic wait_ready(input logic is_load, input req_no_t who);
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (ready_bit(is_load, who) !== 1'b1) begin
			cycles++;
			if (cycles >= 50) begin
				report_timeout($sformatf("%s unit %0d got no ready within 50 cycles",
					is_load ? "load" : "store", who));
			end
			@(negedge clock);
		end
	endtask

	task automatic wait_store_grant();
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (st_ready == '0) begin
			cycles++;
			if (cycles >= 50) begin
				report_timeout("no store unit got ready within 50 cycles");
			end
			@(negedge clock);
		end
	endtask

	// one-cycle end pulse, then the request is withdrawn
	task automatic finish_transfer(input logic is_load, input req_no_t who, input address_t base);
		@(posedge clock);
		drive_end(is_load, who, 1'b1);
		@(posedge clock);
		drive_end(is_load, who, 1'b0);
		drive_req(is_load, who, 1'b0, base);
	endtask

	task automatic run_row(input row_t r);
		address_t base;
		base = pool[r.pick];
		@(posedge clock);
		drive_req(r.is_load, r.who, 1'b1, base);
		if (r.completes) begin
			wait_ready(r.is_load, r.who);
			check_ready(r.is_load, ~r.who, 1'b0);
			finish_transfer(r.is_load, r.who, base);
		end else begin
			repeat (20) begin
				@(negedge clock);
				check_ready(r.is_load, r.who, 1'b0);
			end
			@(posedge clock);
			drive_req(r.is_load, r.who, 1'b0, base);
		end
	endtask

	// both store units ask at once; unit 0 keeps asking after its turn
	task automatic run_grant_order();
		@(posedge clock);
		drive_req(op_store, 1'b0, 1'b1, pool[6]);
		drive_req(op_store, 1'b1, 1'b1, pool[7]);
		wait_store_grant();
		check_grant_order(req_no_t'(0));
		@(posedge clock);
		st_end[0] <= 1'b1;
		@(posedge clock);
		st_end[0] <= 1'b0;
		wait_store_grant();
		check_grant_order(req_no_t'(1));
		@(posedge clock);
		st_end[1] <= 1'b1;
		@(posedge clock);
		st_end[1] <= 1'b0;
		st_req <= '0;
	endtask

	task automatic add_row(input logic is_load, input req_no_t who, input int pick,
			input logic completes);
		row_t r;
		r.is_load   = is_load;
		r.who       = who;
		r.pick      = 3'(pick);
		r.completes = completes;
		rows.push_back(r);
	endtask

	task automatic build_rows();
		// drain the two domains left by the grant order check
		add_row(op_load, 1'b0, 6, ends_done);
		add_row(op_load, 1'b1, 7, ends_done);
		add_row(op_store, 1'b0, 0, ends_done);
		add_row(op_load, 1'b1, 0, ends_done);
		// base 5 is never stored
		add_row(op_load, 1'b0, 5, ends_blocked);
		add_row(op_store, 1'b1, 1, ends_done);
		add_row(op_store, 1'b0, 1, ends_blocked);
		add_row(op_load, 1'b0, 1, ends_done);
		add_row(op_store, 1'b0, 1, ends_done);
		add_row(op_load, 1'b1, 1, ends_done);
		// fill all four entries, then a fifth base has to wait for a load
		add_row(op_store, 1'b0, 0, ends_done);
		add_row(op_store, 1'b1, 1, ends_done);
		add_row(op_store, 1'b0, 2, ends_done);
		add_row(op_store, 1'b1, 3, ends_done);
		add_row(op_store, 1'b0, 4, ends_blocked);
		add_row(op_load, 1'b1, 2, ends_done);
		add_row(op_store, 1'b1, 4, ends_done);
	endtask

	initial begin
		integer rnd;
		seed = 94;
		reset = 1'b1;
		st_req = '0;
		st_base_0 = '0;
		st_base_1 = '0;
		st_end = '0;
		ld_req = '0;
		ld_base_0 = '0;
		ld_base_1 = '0;
		ld_end = '0;
		// low bits carry the pool index so every base is distinct
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			pool[i] = address_t'({rnd[15:3], i[2:0]});
		end
		build_rows();
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		run_grant_order();
		foreach (rows[i]) begin
			run_row(rows[i]);
		end
		repeat (2) @(posedge clock);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- pub_domain_top.sv
//////////////////////////////////////////////////////////////////////
// publish-domain manager top level
// two store units and two load units share four tracked domains
//////////////////////////////////////////////////////////////////////

`include "pub_domain_defs.svh"

module pub_domain_top (
	input  logic                    clock,
	input  logic                    reset,
	input  logic [`NUM_REQ-1:0]     st_req,
	input  tpu_types_pkg::address_t st_base_0,
	input  tpu_types_pkg::address_t st_base_1,
	input  logic [`NUM_REQ-1:0]     st_end,
	output logic [`NUM_REQ-1:0]     st_ready,
	input  logic [`NUM_REQ-1:0]     ld_req,
	input  tpu_types_pkg::address_t ld_base_0,
	input  tpu_types_pkg::address_t ld_base_1,
	input  logic [`NUM_REQ-1:0]     ld_end,
	output logic [`NUM_REQ-1:0]     ld_ready
);

	domain_if st_bus ();
	domain_if ld_bus ();

	// store direction
	pub_domain_arbiter i_st_arbiter (
		.clock     (clock),
		.reset     (reset),
		.req       (st_req),
		.base_0    (st_base_0),
		.base_1    (st_base_1),
		.req_end   (st_end),
		.ready_out (st_ready),
		.bus       (st_bus.arb)
	);

	// load direction, arbitrated independently of the stores
	pub_domain_arbiter i_ld_arbiter (
		.clock     (clock),
		.reset     (reset),
		.req       (ld_req),
		.base_0    (ld_base_0),
		.base_1    (ld_base_1),
		.req_end   (ld_end),
		.ready_out (ld_ready),
		.bus       (ld_bus.arb)
	);

	pub_domain_table i_table (
		.clock (clock),
		.reset (reset),
		.st    (st_bus.tbl),
		.ld    (ld_bus.tbl)
	);

endmodule

//--- pub_domain_table.sv
//////////////////////////////////////////////////////////////////////
// domain tracking table
// decides store and load ready from the granted base and updates the
// entries on each direction's done pulse
//////////////////////////////////////////////////////////////////////

`include "pub_domain_defs.svh"

module pub_domain_table (
	input  logic  clock,
	input  logic  reset,
	domain_if.tbl st,
	domain_if.tbl ld
);
	import tpu_types_pkg::*;

	logic [`NUM_ENTRY-1:0] valid;
	logic [`NUM_ENTRY-1:0] stored;
	address_t              base_tab [`NUM_ENTRY];

	logic      st_hit_any;
	entry_no_t st_hit_no;
	logic      ld_hit_any;
	entry_no_t ld_hit_no;
	logic      free_any;
	entry_no_t free_no;
	logic      st_ok;
	logic      dup_base;

	// exact base match against every valid entry, both directions at once
	always_comb begin
		st_hit_any = 1'b0;
		st_hit_no  = '0;
		ld_hit_any = 1'b0;
		ld_hit_no  = '0;
		for (int i = 0; i < `NUM_ENTRY; i++) begin
			if (valid[i] && base_tab[i] == st.base) begin
				st_hit_any = 1'b1;
				st_hit_no  = entry_no_t'(i);
			end
			// a load only sees data that a store has finished
			if (valid[i] && stored[i] && base_tab[i] == ld.base) begin
				ld_hit_any = 1'b1;
				ld_hit_no  = entry_no_t'(i);
			end
		end
	end

	// lowest free entry, scanned downwards so entry 0 wins
	always_comb begin
		free_any = 1'b0;
		free_no  = '0;
		for (int i = `NUM_ENTRY - 1; i >= 0; i--) begin
			if (!valid[i]) begin
				free_any = 1'b1;
				free_no  = entry_no_t'(i);
			end
		end
	end

	// a store must not overwrite a domain still waiting for its load
	assign st_ok    = st_hit_any ? !stored[st_hit_no] : free_any;
	assign st.ready = st.grant_vld & st_ok;
	assign ld.ready = ld.grant_vld & ld_hit_any;

	always_ff @(posedge clock) begin
		if (reset) begin
			valid  <= '0;
			stored <= '0;
		end else begin
			if (st.done) begin
				if (st_hit_any) begin
					stored[st_hit_no] <= 1'b1;
				end else begin
					valid[free_no]  <= 1'b1;
					stored[free_no] <= 1'b1;
				end
			end
			// the entry released here is always a stored one, so never the store's entry
			if (ld.done) begin
				valid[ld_hit_no]  <= 1'b0;
				stored[ld_hit_no] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (st.done && !st_hit_any) begin
			base_tab[free_no] <= st.base;
		end
	end

	always_comb begin
		dup_base = 1'b0;
		for (int i = 0; i < `NUM_ENTRY; i++) begin
			for (int j = i + 1; j < `NUM_ENTRY; j++) begin
				if (valid[i] && valid[j] && base_tab[i] == base_tab[j]) begin
					dup_base = 1'b1;
				end
			end
		end
	end

	// end pulses from the requesters are only legal while ready is shown
	a_done_needs_ready: assert property (
		@(posedge clock) disable iff (reset)
		(st.done |-> st.ready) and (ld.done |-> ld.ready)
	) else $error("done without ready");

	a_load_done_hits: assert property (
		@(posedge clock) disable iff (reset)
		ld.done |-> ld_hit_any
	) else $error("load done on a base with no stored entry");

	// allocation only happens on a miss, so a base lives in one entry at most
	a_unique_base: assert property (
		@(posedge clock) disable iff (reset)
		!dup_base
	) else $error("two valid entries share a base");

endmodule

//--- pub_domain_arbiter.sv
//////////////////////////////////////////////////////////////////////
// round-robin arbiter for the two requesters of one direction
// holds the grant until the winner pulses end or drops its request
//////////////////////////////////////////////////////////////////////

`include "pub_domain_defs.svh"

module pub_domain_arbiter (
	input  logic                   clock,
	input  logic                   reset,
	input  logic [`NUM_REQ-1:0]    req,
	input  tpu_types_pkg::address_t base_0,
	input  tpu_types_pkg::address_t base_1,
	input  logic [`NUM_REQ-1:0]    req_end,
	output logic [`NUM_REQ-1:0]    ready_out,
	domain_if.arb                  bus
);
	import tpu_types_pkg::*;
	import tpu_ctrl_pkg::*;

	arb_state_t state;

	// requester that gets first pick at the next arbitration
	req_no_t prio;

	req_no_t grant_no_r;
	req_no_t winner;
	logic    busy;

	assign busy = (state == arb_busy);

	// the priority holder wins if it asks, otherwise the other one
	always_comb begin
		if (req[prio]) begin
			winner = prio;
		end else begin
			winner = ~prio;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= arb_idle;
			prio       <= '0;
			grant_no_r <= '0;
		end else begin
			case (state)
				arb_idle: begin
					if (|req) begin
						state      <= arb_busy;
						grant_no_r <= winner;
						prio       <= ~winner;
					end
				end
				arb_busy: begin
					// a blocked requester may give up, which frees the grant too
					if (bus.done || !req[grant_no_r]) begin
						state <= arb_idle;
					end
				end
				default: begin
					state <= arb_idle;
				end
			endcase
		end
	end

	assign bus.grant_vld = busy;
	assign bus.grant_no  = grant_no_r;
	assign bus.base      = (grant_no_r == req_no_t'(1)) ? base_1 : base_0;
	assign bus.done      = busy & req_end[grant_no_r];

	// ready from the table goes back only to the requester holding the grant
	always_comb begin
		for (int i = 0; i < `NUM_REQ; i++) begin
			ready_out[i] = busy & bus.ready & (grant_no_r == req_no_t'(i));
		end
	end

endmodule

//--- domain_if.sv
//////////////////////////////////////////////////////////////////////
// one direction's grant handshake between its arbiter and the table
// instantiate once for the store side and once for the load side
//////////////////////////////////////////////////////////////////////

interface domain_if;
	import tpu_types_pkg::*;

	logic     grant_vld;
	req_no_t  grant_no;
	address_t base;
	logic     done;
	logic     ready;

	modport arb (
		output grant_vld,
		output grant_no,
		output base,
		output done,
		input  ready
	);

	// the table only needs the winner's base, not who the winner is
	modport tbl (
		input  grant_vld,
		input  base,
		input  done,
		output ready
	);

endinterface

//--- tpu_ctrl_pkg.sv
//////////////////////////////////////////////////////////////////////
// control types of the publish-domain manager
//////////////////////////////////////////////////////////////////////

package tpu_ctrl_pkg;

	// an arbiter is either free or holding a grant
	typedef enum logic {
		arb_idle,
		arb_busy
	} arb_state_t;

endpackage

//--- tpu_types_pkg.sv
//////////////////////////////////////////////////////////////////////
// datapath types shared by the publish-domain manager and its testbench
// addresses, table entry indices and requester numbers
//////////////////////////////////////////////////////////////////////

`include "pub_domain_defs.svh"

package tpu_types_pkg;

	// base address that names a memory domain
	typedef logic [`ADDR_WIDTH-1:0] address_t;

	// index of one entry of the tracking table
	typedef logic [$clog2(`NUM_ENTRY)-1:0] entry_no_t;

	// number of a requester inside one direction
	typedef logic [$clog2(`NUM_REQ)-1:0] req_no_t;

endpackage

//--- pub_domain_defs.svh
//////////////////////////////////////////////////////////////////////
// sizing macros for the publish-domain manager
// include this wherever a width or count of the design is needed
//////////////////////////////////////////////////////////////////////

`ifndef PUB_DOMAIN_DEFS_SVH
`define PUB_DOMAIN_DEFS_SVH

// entries in the domain tracking table
`define NUM_ENTRY 4

// width of a domain base address
`define ADDR_WIDTH 16

// requesters per direction, store or load
`define NUM_REQ 2

`endif
